// File: Makefile
VERILATOR := verilator
TOP       := tb_periph_soc
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
# Assertion errors do not stop the run, so the testbench reports them and exits through $fatal
RUN_FLAGS := +verilator+error+limit+100
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard source/*.sv source/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	$(SIM) $(RUN_FLAGS)

clean:
	rm -rf $(OBJ_DIR)

// File: source/axil_decoder.sv
// AXI4-Lite slave with one transaction in flight; a write wins over a read in the same cycle
// Targets answer in the handshake cycle and the response is registered for the next one
// The UART region is 16 bytes; anything outside RAM and UART gets DECERR
`timescale 1ns/1ps
`include "soc_cfg.svh"

module axil_decoder import soc_pkg::*; (
    input  logic        clock,
    input  logic        reset_i,
    input  axil_addr_t  s_awaddr_i,
    input  logic        s_awvalid_i,
    output logic        s_awready_o,
    input  axil_data_t  s_wdata_i,
    input  axil_strb_t  s_wstrb_i,
    input  logic        s_wvalid_i,
    output logic        s_wready_o,
    output axil_resp_t  s_bresp_o,
    output logic        s_bvalid_o,
    input  logic        s_bready_i,
    input  axil_addr_t  s_araddr_i,
    input  logic        s_arvalid_i,
    output logic        s_arready_o,
    output axil_data_t  s_rdata_o,
    output axil_resp_t  s_rresp_o,
    output logic        s_rvalid_o,
    input  logic        s_rready_i,
    output logic        ram_sel_o,
    output logic        uart_sel_o,
    output logic        we_o,
    output word_addr_t  word_addr_o,
    output axil_data_t  wdata_o,
    output axil_strb_t  wstrb_o,
    input  axil_data_t  ram_rdata_i,
    input  axil_data_t  uart_rdata_i,
    input  logic        uart_err_i
);
    localparam axil_addr_t ram_mask = axil_addr_t'(`SOC_RAM_WORDS * 4 - 1);
    localparam axil_addr_t uart_mask = axil_addr_t'(15);
    localparam int word_aw = $bits(word_addr_t);

    logic        bvalid_q;
    logic        rvalid_q;
    axil_resp_t  bresp_q;
    axil_resp_t  rresp_q;
    axil_data_t  rdata_q;
    logic        pending;
    logic        wr_go;
    logic        rd_go;
    axil_addr_t  req_addr;
    target_sel_t target;
    axil_resp_t  resp_now;
    axil_data_t  rdata_now;

    function automatic target_sel_t decode(input axil_addr_t addr);
        if ((addr & ~ram_mask) == `SOC_RAM_BASE) begin
            return SEL_RAM;
        end
        if ((addr & ~uart_mask) == `SOC_UART_BASE) begin
            return SEL_UART;
        end
        return SEL_NONE;
    endfunction

    // Nothing new is taken while a B or R response waits
    assign pending = bvalid_q | rvalid_q;
    assign s_awready_o = ~pending & s_awvalid_i & s_wvalid_i;
    assign s_wready_o = s_awready_o;
    assign s_arready_o = ~pending & s_arvalid_i & ~(s_awvalid_i & s_wvalid_i);
    assign wr_go = s_awready_o;
    assign rd_go = s_arready_o;

    assign req_addr = wr_go ? s_awaddr_i : s_araddr_i;
    assign target = decode(req_addr);
    assign ram_sel_o = (wr_go | rd_go) & (target == SEL_RAM);
    assign uart_sel_o = (wr_go | rd_go) & (target == SEL_UART);
    assign we_o = wr_go;
    assign word_addr_o = req_addr[word_aw+1:2];
    assign wdata_o = s_wdata_i;
    assign wstrb_o = s_wstrb_i;

    always_comb begin
        case (target)
            SEL_RAM: begin
                resp_now = RESP_OKAY;
                rdata_now = ram_rdata_i;
            end
            SEL_UART: begin
                resp_now = uart_err_i ? RESP_SLVERR : RESP_OKAY;
                rdata_now = uart_rdata_i;
            end
            default: begin
                resp_now = RESP_DECERR;
                rdata_now = '0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset_i) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_go) begin
                bvalid_q <= 1'b1;
            end else if (s_bready_i) begin
                bvalid_q <= 1'b0;
            end
            if (rd_go) begin
                rvalid_q <= 1'b1;
            end else if (s_rready_i) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // Payload only loads on acceptance, so it stays put under back-pressure
    always_ff @(posedge clock) begin
        if (wr_go) begin
            bresp_q <= resp_now;
        end
        if (rd_go) begin
            rresp_q <= resp_now;
            rdata_q <= rdata_now;
        end
    end

    assign s_bvalid_o = bvalid_q;
    assign s_bresp_o = bresp_q;
    assign s_rvalid_o = rvalid_q;
    assign s_rresp_o = rresp_q;
    assign s_rdata_o = rdata_q;

endmodule

// File: source/byte_fifo.sv
// Byte FIFO, first-word fall-through on pop_byte_o
// A push while full or a pop while empty is ignored
`timescale 1ns/1ps
`include "soc_cfg.svh"

module byte_fifo import soc_pkg::*; #(
    parameter int depth = `SOC_UART_FIFO_DEPTH
) (
    input  logic        clock,
    input  logic        reset_i,
    input  logic        push_i,
    input  uart_byte_t  push_byte_i,
    input  logic        pop_i,
    output uart_byte_t  pop_byte_o,
    output logic        full_o,
    output logic        empty_o
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    uart_byte_t       mem [depth];
    logic [ptr_w-1:0] wr_ptr_q;
    logic [ptr_w-1:0] rd_ptr_q;
    logic [ptr_w:0]   count_q;
    logic             do_push;
    logic             do_pop;

    assign full_o = (count_q == (ptr_w+1)'(depth));
    assign empty_o = (count_q == '0);
    assign do_push = push_i & ~full_o;
    assign do_pop = pop_i & ~empty_o;
    assign pop_byte_o = mem[rd_ptr_q];

    always_ff @(posedge clock) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + do_push - do_pop;
        end
    end

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_byte_i;
        end
    end

endmodule

// File: source/periph_ram.sv
// Word RAM with byte-strobe writes and combinational read
// Contents are not initialised
`timescale 1ns/1ps
`include "soc_cfg.svh"

module periph_ram import soc_pkg::*; (
    input  logic        clock,
    input  logic        sel_i,
    input  logic        we_i,
    input  word_addr_t  word_addr_i,
    input  axil_data_t  wdata_i,
    input  axil_strb_t  wstrb_i,
    output axil_data_t  rdata_o
);
    axil_data_t mem [`SOC_RAM_WORDS];

    always_ff @(posedge clock) begin
        if (sel_i && we_i) begin
            for (int b = 0; b < 4; b++) begin
                // Only lanes with a strobe change
                if (wstrb_i[b]) begin
                    mem[word_addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    assign rdata_o = mem[word_addr_i];

endmodule

// File: source/periph_soc.sv
// Peripheral SoC top: AXI4-Lite port, word RAM and UART
// RX bytes arriving while the RX FIFO is full are lost
`timescale 1ns/1ps

module periph_soc import soc_pkg::*; (
    input  logic        clock,
    input  logic        reset_i,
    input  axil_addr_t  s_awaddr_i,
    input  logic        s_awvalid_i,
    output logic        s_awready_o,
    input  axil_data_t  s_wdata_i,
    input  axil_strb_t  s_wstrb_i,
    input  logic        s_wvalid_i,
    output logic        s_wready_o,
    output axil_resp_t  s_bresp_o,
    output logic        s_bvalid_o,
    input  logic        s_bready_i,
    input  axil_addr_t  s_araddr_i,
    input  logic        s_arvalid_i,
    output logic        s_arready_o,
    output axil_data_t  s_rdata_o,
    output axil_resp_t  s_rresp_o,
    output logic        s_rvalid_o,
    input  logic        s_rready_i,
    input  logic        srx_i,
    output logic        stx_o,
    output logic        irq_o
);
    logic       ram_sel;
    logic       uart_sel;
    logic       we;
    word_addr_t word_addr;
    axil_data_t wdata;
    axil_strb_t wstrb;
    axil_data_t ram_rdata;
    axil_data_t uart_rdata;
    logic       uart_err;
    logic       tx_push;
    uart_byte_t tx_byte;
    logic       tx_full;
    logic       tx_empty;
    logic       tx_pop;
    uart_byte_t tx_head;
    logic       tx_busy;
    logic       rx_push;
    uart_byte_t rx_byte;
    logic       rx_pop;
    uart_byte_t rx_head;
    logic       rx_empty;

    axil_decoder u_decoder (
        .clock, .reset_i,
        .s_awaddr_i, .s_awvalid_i, .s_awready_o,
        .s_wdata_i, .s_wstrb_i, .s_wvalid_i, .s_wready_o,
        .s_bresp_o, .s_bvalid_o, .s_bready_i,
        .s_araddr_i, .s_arvalid_i, .s_arready_o,
        .s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
        .ram_sel_o(ram_sel), .uart_sel_o(uart_sel), .we_o(we),
        .word_addr_o(word_addr), .wdata_o(wdata), .wstrb_o(wstrb),
        .ram_rdata_i(ram_rdata), .uart_rdata_i(uart_rdata), .uart_err_i(uart_err)
    );

    periph_ram u_ram (
        .clock, .sel_i(ram_sel), .we_i(we), .word_addr_i(word_addr),
        .wdata_i(wdata), .wstrb_i(wstrb), .rdata_o(ram_rdata)
    );

    uart_regs u_uart_regs (
        .sel_i(uart_sel), .we_i(we), .word_addr_i(word_addr), .wdata_i(wdata),
        .rdata_o(uart_rdata), .err_o(uart_err),
        .tx_push_o(tx_push), .tx_byte_o(tx_byte), .tx_full_i(tx_full),
        .rx_pop_o(rx_pop), .rx_byte_i(rx_head), .rx_empty_i(rx_empty),
        .tx_busy_i(tx_busy), .irq_o
    );

    byte_fifo u_tx_fifo (
        .clock, .reset_i, .push_i(tx_push), .push_byte_i(tx_byte),
        .pop_i(tx_pop), .pop_byte_o(tx_head), .full_o(tx_full), .empty_o(tx_empty)
    );

    uart_tx u_uart_tx (
        .clock, .reset_i, .empty_i(tx_empty), .byte_i(tx_head),
        .pop_o(tx_pop), .busy_o(tx_busy), .stx_o
    );

    uart_rx u_uart_rx (
        .clock, .reset_i, .srx_i, .push_o(rx_push), .byte_o(rx_byte)
    );

    byte_fifo u_rx_fifo (
        .clock, .reset_i, .push_i(rx_push), .push_byte_i(rx_byte),
        .pop_i(rx_pop), .pop_byte_o(rx_head), .full_o(), .empty_o(rx_empty)
    );

endmodule

// File: source/soc_cfg.svh
// Address map, RAM size and UART settings shared by RTL and testbench
// Region bases must be aligned to their region size
// SOC_UART_CLKS_PER_BIT must be 2 or more
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

`define SOC_RAM_BASE          32'h0000_0000
`define SOC_RAM_WORDS         256
`define SOC_UART_BASE         32'h0000_1000
`define SOC_UART_TXDATA       32'h0
`define SOC_UART_RXDATA       32'h4
`define SOC_UART_STATUS       32'h8
`define SOC_UART_CLKS_PER_BIT 8
`define SOC_UART_FIFO_DEPTH   4

`endif

// File: source/soc_pkg.sv
// Bus, response, target and character types for the peripheral SoC
`include "soc_cfg.svh"

package soc_pkg;

    typedef logic [31:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;
    typedef logic [$clog2(`SOC_RAM_WORDS)-1:0] word_addr_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axil_resp_t;

    typedef enum logic [1:0] {SEL_RAM, SEL_UART, SEL_NONE} target_sel_t;

    typedef logic [7:0] uart_byte_t;

endpackage

// File: source/uart_regs.sv
// UART register block, purely combinational
// Full TX FIFO on write or empty RX FIFO on read gives an error; so does an unused offset
`timescale 1ns/1ps
`include "soc_cfg.svh"

module uart_regs import soc_pkg::*; (
    input  logic        sel_i,
    input  logic        we_i,
    input  word_addr_t  word_addr_i,
    input  axil_data_t  wdata_i,
    output axil_data_t  rdata_o,
    output logic        err_o,
    output logic        tx_push_o,
    output uart_byte_t  tx_byte_o,
    input  logic        tx_full_i,
    output logic        rx_pop_o,
    input  uart_byte_t  rx_byte_i,
    input  logic        rx_empty_i,
    input  logic        tx_busy_i,
    output logic        irq_o
);
    localparam word_addr_t tx_word = word_addr_t'(`SOC_UART_TXDATA / 4);
    localparam word_addr_t rx_word = word_addr_t'(`SOC_UART_RXDATA / 4);
    localparam word_addr_t status_word = word_addr_t'(`SOC_UART_STATUS / 4);

    assign tx_push_o = sel_i & we_i & (word_addr_i == tx_word) & ~tx_full_i;
    assign tx_byte_o = wdata_i[7:0];
    assign rx_pop_o = sel_i & ~we_i & (word_addr_i == rx_word) & ~rx_empty_i;
    assign irq_o = ~rx_empty_i;

    always_comb begin
        rdata_o = '0;
        err_o = 1'b0;
        if (sel_i) begin
            case (word_addr_i)
                tx_word: begin
                    err_o = we_i & tx_full_i;
                end
                rx_word: begin
                    if (!we_i) begin
                        err_o = rx_empty_i;
                        rdata_o = rx_empty_i ? '0 : {24'b0, rx_byte_i};
                    end
                end
                status_word: begin
                    // Bit 0 tx full, bit 1 rx ready, bit 2 tx busy
                    rdata_o = {29'b0, tx_busy_i, ~rx_empty_i, tx_full_i};
                end
                default: begin
                    err_o = 1'b1;
                end
            endcase
        end
    end

endmodule

// File: source/uart_rx.sv
// 8N1 deserializer, samples mid-bit after a falling edge on the synchronized line
// A low stop bit drops the byte; a start bit high at mid-bit is taken as a glitch
`timescale 1ns/1ps
`include "soc_cfg.svh"

module uart_rx import soc_pkg::*; (
    input  logic        clock,
    input  logic        reset_i,
    input  logic        srx_i,
    output logic        push_o,
    output uart_byte_t  byte_o
);
    localparam int cpb = `SOC_UART_CLKS_PER_BIT;
    localparam int cnt_w = (cpb > 1) ? $clog2(cpb) : 1;

    logic [2:0]       sync_q;
    logic             rx_s;
    logic             active_q;
    logic [3:0]       bit_idx_q;
    logic [cnt_w-1:0] clk_cnt_q;
    logic             push_q;
    uart_byte_t       shift_q;

    assign rx_s = sync_q[1];
    assign push_o = push_q;
    assign byte_o = shift_q;

    always_ff @(posedge clock) begin
        if (reset_i) begin
            sync_q <= '1;
            active_q <= 1'b0;
            bit_idx_q <= '0;
            clk_cnt_q <= '0;
            push_q <= 1'b0;
        end else begin
            sync_q <= {sync_q[1:0], srx_i};
            push_q <= 1'b0;
            if (!active_q) begin
                if (sync_q[2] && !rx_s) begin
                    active_q <= 1'b1;
                    bit_idx_q <= '0;
                    clk_cnt_q <= cnt_w'(cpb / 2 - 1);
                end
            end else if (clk_cnt_q != '0) begin
                clk_cnt_q <= clk_cnt_q - 1'b1;
            end else begin
                clk_cnt_q <= cnt_w'(cpb - 1);
                bit_idx_q <= bit_idx_q + 1'b1;
                if (bit_idx_q == 4'd0 && rx_s) begin
                    active_q <= 1'b0;
                end
                if (bit_idx_q == 4'd9) begin
                    active_q <= 1'b0;
                    push_q <= rx_s;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (active_q && clk_cnt_q == '0 && bit_idx_q >= 4'd1 && bit_idx_q <= 4'd8) begin
            shift_q <= {rx_s, shift_q[7:1]};
        end
    end

endmodule

// File: source/uart_tx.sv
// 8N1 serializer, takes the next byte from the FIFO as soon as it is idle
// Line idles high
`timescale 1ns/1ps
`include "soc_cfg.svh"

module uart_tx import soc_pkg::*; (
    input  logic        clock,
    input  logic        reset_i,
    input  logic        empty_i,
    input  uart_byte_t  byte_i,
    output logic        pop_o,
    output logic        busy_o,
    output logic        stx_o
);
    localparam int cpb = `SOC_UART_CLKS_PER_BIT;
    localparam int cnt_w = (cpb > 1) ? $clog2(cpb) : 1;

    logic             busy_q;
    logic [9:0]       shift_q;
    logic [3:0]       bit_cnt_q;
    logic [cnt_w-1:0] clk_cnt_q;

    assign pop_o = ~busy_q & ~empty_i;
    assign busy_o = busy_q;
    assign stx_o = busy_q ? shift_q[0] : 1'b1;

    always_ff @(posedge clock) begin
        if (reset_i) begin
            busy_q <= 1'b0;
            bit_cnt_q <= '0;
            clk_cnt_q <= '0;
        end else if (!busy_q) begin
            if (!empty_i) begin
                busy_q <= 1'b1;
                bit_cnt_q <= '0;
                clk_cnt_q <= '0;
            end
        end else if (clk_cnt_q == cnt_w'(cpb - 1)) begin
            clk_cnt_q <= '0;
            // Stop bit is bit 9
            if (bit_cnt_q == 4'd9) begin
                busy_q <= 1'b0;
            end else begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
        end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
        end
    end

    // Frame is stop, data LSB first, start
    always_ff @(posedge clock) begin
        if (!busy_q && !empty_i) begin
            shift_q <= {1'b1, byte_i, 1'b0};
        end else if (busy_q && clk_cnt_q == cnt_w'(cpb - 1)) begin
            shift_q <= {1'b1, shift_q[9:1]};
        end
    end

endmodule

// File: verif/periph_soc_properties.sv
// Handshake and reset checks for periph_soc, bound into every instance
// prop_failed stays high once any assertion has failed
`timescale 1ns/1ps

module periph_soc_properties import soc_pkg::*; (
    input logic        clock,
    input logic        reset_i,
    input axil_addr_t  s_awaddr_i,
    input logic        s_awvalid_i,
    input logic        s_awready_o,
    input axil_data_t  s_wdata_i,
    input axil_strb_t  s_wstrb_i,
    input logic        s_wvalid_i,
    input logic        s_bvalid_o,
    input axil_resp_t  s_bresp_o,
    input logic        s_bready_i,
    input axil_addr_t  s_araddr_i,
    input logic        s_arvalid_i,
    input logic        s_arready_o,
    input axil_data_t  s_rdata_o,
    input axil_resp_t  s_rresp_o,
    input logic        s_rvalid_o,
    input logic        s_rready_i,
    input logic        stx_o,
    input logic        irq_o
);
    logic aw_hold_bad = 1'b0;
    logic ar_hold_bad = 1'b0;
    logic b_hold_bad = 1'b0;
    logic r_hold_bad = 1'b0;
    logic b_orphan_bad = 1'b0;
    logic r_orphan_bad = 1'b0;
    logic reset_bad = 1'b0;
    logic prop_failed;

    assign prop_failed = aw_hold_bad | ar_hold_bad | b_hold_bad | r_hold_bad
                       | b_orphan_bad | r_orphan_bad | reset_bad;

    // Requests hold until accepted
    aw_hold: assert property (@(posedge clock) disable iff (reset_i)
        s_awvalid_i && !s_awready_o |=> s_awvalid_i && s_wvalid_i && $stable(s_awaddr_i)
            && $stable(s_wdata_i) && $stable(s_wstrb_i))
        else begin
            aw_hold_bad = 1'b1;
            $error("AW or W changed before it was accepted");
        end
    ar_hold: assert property (@(posedge clock) disable iff (reset_i)
        s_arvalid_i && !s_arready_o |=> s_arvalid_i && $stable(s_araddr_i))
        else begin
            ar_hold_bad = 1'b1;
            $error("AR changed before it was accepted");
        end

    // Responses hold under back-pressure
    b_hold: assert property (@(posedge clock) disable iff (reset_i)
        s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o))
        else begin
            b_hold_bad = 1'b1;
            $error("B response changed before bready");
        end
    r_hold: assert property (@(posedge clock) disable iff (reset_i)
        s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o))
        else begin
            r_hold_bad = 1'b1;
            $error("R response changed before rready");
        end

    b_orphan: assert property (@(posedge clock) disable iff (reset_i)
        $rose(s_bvalid_o) |-> $past(s_awvalid_i && s_awready_o))
        else begin
            b_orphan_bad = 1'b1;
            $error("B response without an accepted write");
        end
    r_orphan: assert property (@(posedge clock) disable iff (reset_i)
        $rose(s_rvalid_o) |-> $past(s_arvalid_i && s_arready_o))
        else begin
            r_orphan_bad = 1'b1;
            $error("R response without an accepted read");
        end

    reset_state: assert property (@(posedge clock)
        reset_i |=> !s_bvalid_o && !s_rvalid_o && !s_awready_o && !s_arready_o
            && !irq_o && stx_o)
        else begin
            reset_bad = 1'b1;
            $error("outputs not idle after reset");
        end

endmodule

bind periph_soc periph_soc_properties u_props (
    .clock, .reset_i,
    .s_awaddr_i, .s_awvalid_i, .s_awready_o, .s_wdata_i, .s_wstrb_i, .s_wvalid_i,
    .s_bvalid_o, .s_bresp_o, .s_bready_i,
    .s_araddr_i, .s_arvalid_i, .s_arready_o,
    .s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
    .stx_o, .irq_o
);

// File: verif/tb_periph_soc.sv
// Testbench for periph_soc with the UART looped back (stx_o drives srx_i)
// Inputs change on the rising edge and outputs are sampled on the falling edge
// RAM words are read only after the testbench has written them in full
`timescale 1ns/1ps
`include "soc_cfg.svh"

module tb_periph_soc import soc_pkg::*; ();
    localparam int hs_limit = 64;
    localparam int poll_limit = 200;

    logic        clock;
    logic        reset_i;
    axil_addr_t  s_awaddr_i;
    logic        s_awvalid_i;
    logic        s_awready_o;
    axil_data_t  s_wdata_i;
    axil_strb_t  s_wstrb_i;
    logic        s_wvalid_i;
    logic        s_wready_o;
    axil_resp_t  s_bresp_o;
    logic        s_bvalid_o;
    logic        s_bready_i;
    axil_addr_t  s_araddr_i;
    logic        s_arvalid_i;
    logic        s_arready_o;
    axil_data_t  s_rdata_o;
    axil_resp_t  s_rresp_o;
    logic        s_rvalid_o;
    logic        s_rready_i;
    wire         serial_line;
    logic        irq_o;

    logic [31:0] lcg_state;
    axil_data_t  ram_model [`SOC_RAM_WORDS];
    int          ram_used [$];
    uart_byte_t  rx_expect [$];

    periph_soc uut (
        .clock, .reset_i,
        .s_awaddr_i, .s_awvalid_i, .s_awready_o,
        .s_wdata_i, .s_wstrb_i, .s_wvalid_i, .s_wready_o,
        .s_bresp_o, .s_bvalid_o, .s_bready_i,
        .s_araddr_i, .s_arvalid_i, .s_arready_o,
        .s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
        .srx_i(serial_line), .stx_o(serial_line), .irq_o
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic logic [15:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    // Ready stays low for 0 to 3 cycles
    function automatic int random_hold();
        return int'(next_random() % 16'd4);
    endfunction

    function automatic axil_data_t merge_bytes(input axil_data_t old_word,
                                               input axil_data_t new_word,
                                               input axil_strb_t strb);
        axil_data_t res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            report_failure($sformatf("ERR t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic write_word(input axil_addr_t addr, input axil_data_t data,
                              input axil_strb_t strb, input int hold,
                              output axil_resp_t resp);
        int wait_n;
        @(posedge clock);
        s_awaddr_i <= addr;
        s_awvalid_i <= 1'b1;
        s_wdata_i <= data;
        s_wstrb_i <= strb;
        s_wvalid_i <= 1'b1;
        wait_n = 0;
        @(negedge clock);
        while (!(s_awready_o && s_wready_o)) begin
            wait_n++;
            if (wait_n > hs_limit) begin
                report_failure("timeout waiting for awready and wready");
            end
            @(negedge clock);
        end
        @(posedge clock);
        s_awvalid_i <= 1'b0;
        s_wvalid_i <= 1'b0;
        wait_n = 0;
        @(negedge clock);
        while (!s_bvalid_o) begin
            wait_n++;
            if (wait_n > hs_limit) begin
                report_failure("timeout waiting for bvalid");
            end
            @(negedge clock);
        end
        repeat (hold) @(posedge clock);
        @(posedge clock);
        s_bready_i <= 1'b1;
        @(negedge clock);
        resp = s_bresp_o;
        @(posedge clock);
        s_bready_i <= 1'b0;
    endtask

    task automatic read_word(input axil_addr_t addr, input int hold,
                             output axil_data_t data, output axil_resp_t resp);
        int wait_n;
        @(posedge clock);
        s_araddr_i <= addr;
        s_arvalid_i <= 1'b1;
        wait_n = 0;
        @(negedge clock);
        while (!s_arready_o) begin
            wait_n++;
            if (wait_n > hs_limit) begin
                report_failure("timeout waiting for arready");
            end
            @(negedge clock);
        end
        @(posedge clock);
        s_arvalid_i <= 1'b0;
        wait_n = 0;
        @(negedge clock);
        while (!s_rvalid_o) begin
            wait_n++;
            if (wait_n > hs_limit) begin
                report_failure("timeout waiting for rvalid");
            end
            @(negedge clock);
        end
        repeat (hold) @(posedge clock);
        @(posedge clock);
        s_rready_i <= 1'b1;
        @(negedge clock);
        data = s_rdata_o;
        resp = s_rresp_o;
        @(posedge clock);
        s_rready_i <= 1'b0;
    endtask

    // Poll STATUS for each expected byte, then read it from RXDATA
    task automatic receive_expected();
        axil_data_t data;
        axil_resp_t resp;
        uart_byte_t want;
        int         polls;
        while (rx_expect.size() > 0) begin
            polls = 0;
            data = '0;
            while (!data[1]) begin
                polls++;
                if (polls > poll_limit) begin
                    report_failure("timeout waiting for a received byte in STATUS");
                end
                read_word(`SOC_UART_BASE + `SOC_UART_STATUS, random_hold(), data, resp);
            end
            @(negedge clock);
            expect_value("irq_o", 32'(irq_o), 32'd1);
            want = rx_expect.pop_front();
            read_word(`SOC_UART_BASE + `SOC_UART_RXDATA, random_hold(), data, resp);
            expect_value("s_rresp_o", 32'(resp), 32'(RESP_OKAY));
            expect_value("s_rdata_o", data, {24'd0, want});
        end
        @(negedge clock);
        expect_value("irq_o", 32'(irq_o), 32'd0);
    endtask

    // Bound checker raises prop_failed after a failed assertion
    always @(negedge clock) begin
        if (uut.u_props.prop_failed) begin
            report_failure("a bus handshake or reset assertion failed inside the DUT");
        end
    end

    initial begin
        axil_resp_t resp;
        axil_data_t data;
        axil_strb_t strb;
        axil_addr_t addr;
        uart_byte_t b;
        int         idx;
        int         dropped;
        lcg_state = 32'd78;
        reset_i = 1'b1;
        s_awaddr_i = '0;
        s_awvalid_i = 1'b0;
        s_wdata_i = '0;
        s_wstrb_i = '0;
        s_wvalid_i = 1'b0;
        s_bready_i = 1'b0;
        s_araddr_i = '0;
        s_arvalid_i = 1'b0;
        s_rready_i = 1'b0;
        repeat (5) @(posedge clock);
        reset_i <= 1'b0;

        @(negedge clock);
        expect_value("s_bvalid_o", 32'(s_bvalid_o), 32'd0);
        expect_value("s_rvalid_o", 32'(s_rvalid_o), 32'd0);
        expect_value("irq_o", 32'(irq_o), 32'd0);
        expect_value("stx_o", 32'(serial_line), 32'd1);
        read_word(`SOC_UART_BASE + `SOC_UART_STATUS, 0, data, resp);
        expect_value("STATUS bit 1", 32'(data[1]), 32'd0);

        // Full-word writes first, then random strobes over the same words
        for (int i = 0; i < 12; i++) begin
            idx = int'(next_random() % 16'(`SOC_RAM_WORDS));
            data = {next_random(), next_random()};
            write_word(`SOC_RAM_BASE + axil_addr_t'(idx * 4), data, 4'hF, random_hold(), resp);
            expect_value("s_bresp_o", 32'(resp), 32'(RESP_OKAY));
            ram_model[idx] = data;
            ram_used.push_back(idx);
        end
        foreach (ram_used[k]) begin
            addr = `SOC_RAM_BASE + axil_addr_t'(ram_used[k] * 4);
            strb = axil_strb_t'(next_random());
            data = {next_random(), next_random()};
            write_word(addr, data, strb, random_hold(), resp);
            expect_value("s_bresp_o", 32'(resp), 32'(RESP_OKAY));
            ram_model[ram_used[k]] = merge_bytes(ram_model[ram_used[k]], data, strb);
        end
        foreach (ram_used[k]) begin
            addr = `SOC_RAM_BASE + axil_addr_t'(ram_used[k] * 4);
            read_word(addr, random_hold(), data, resp);
            expect_value("s_rresp_o", 32'(resp), 32'(RESP_OKAY));
            expect_value("s_rdata_o", data, ram_model[ram_used[k]]);
        end

        write_word(32'h0000_2000, 32'hDEAD_BEEF, 4'hF, random_hold(), resp);
        expect_value("s_bresp_o", 32'(resp), 32'(RESP_DECERR));
        read_word(32'h0000_0400, random_hold(), data, resp);
        expect_value("s_rresp_o", 32'(resp), 32'(RESP_DECERR));
        expect_value("s_rdata_o", data, 32'd0);
        read_word(32'h0000_1010, random_hold(), data, resp);
        expect_value("s_rresp_o", 32'(resp), 32'(RESP_DECERR));
        expect_value("s_rdata_o", data, 32'd0);

        for (int i = 0; i < 3; i++) begin
            b = uart_byte_t'(next_random());
            write_word(`SOC_UART_BASE + `SOC_UART_TXDATA, {24'd0, b}, 4'hF, random_hold(), resp);
            expect_value("s_bresp_o", 32'(resp), 32'(RESP_OKAY));
            rx_expect.push_back(b);
        end
        receive_expected();
        read_word(`SOC_UART_BASE + `SOC_UART_RXDATA, random_hold(), data, resp);
        expect_value("s_rresp_o", 32'(resp), 32'(RESP_SLVERR));
        expect_value("s_rdata_o", data, 32'd0);

        // Back-to-back writes, faster than one frame, overrun the TX FIFO
        dropped = 0;
        for (int i = 0; i < 8; i++) begin
            b = uart_byte_t'(next_random());
            write_word(`SOC_UART_BASE + `SOC_UART_TXDATA, {24'd0, b}, 4'hF, 0, resp);
            if (resp == RESP_OKAY) begin
                rx_expect.push_back(b);
            end else begin
                expect_value("s_bresp_o", 32'(resp), 32'(RESP_SLVERR));
                dropped++;
            end
        end
        assert (dropped > 0) else begin
            report_failure("transmit FIFO never reported an overflow");
        end
        receive_expected();
        // Two frame times, long enough for any stray byte to land
        repeat (2 * 10 * `SOC_UART_CLKS_PER_BIT) @(posedge clock);
        read_word(`SOC_UART_BASE + `SOC_UART_STATUS, 0, data, resp);
        expect_value("STATUS bit 1", 32'(data[1]), 32'd0);
        @(negedge clock);
        expect_value("irq_o", 32'(irq_o), 32'd0);

        $display("** PASS **");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+source
source/soc_pkg.sv
source/axil_decoder.sv
source/periph_ram.sv
source/uart_regs.sv
source/byte_fifo.sv
source/uart_tx.sv
source/uart_rx.sv
source/periph_soc.sv
verif/periph_soc_properties.sv
verif/tb_periph_soc.sv
